// File: cfgProtocolPkg.sv
package cfgProtocolPkg;

	// 32-bit aligned marker that opens a configuration stream
	localparam logic [31:0] SyncWord = 32'hFAB0_FAB1;

	// header bit that drops the FSM back to unsynced
	localparam int DesyncBit = 20;

	typedef logic [31:0] cfgWord_t; // one packed stream word

	// header word layout, msb first
	typedef struct packed {
		logic [7:0]  colIdx;     // target column
		logic [2:0]  reservedHi; // unused, sent as zero
		logic        desync;     // bit 20, ends the session
		logic [14:0] reservedLo; // unused, sent as zero
		logic [4:0]  frameIdx;   // frame within the column
	} frameHeader_t;

	// configuration FSM states
	typedef enum logic [1:0] {
		unsynced = 2'd0, // hunting for SyncWord
		synced   = 2'd1, // waiting for a header
		loadRows = 2'd2  // taking one data word per row
	} cfgState_t;

endpackage

// File: fabricGeomPkg.sv
package fabricGeomPkg;

	// default fabric size, top level may override
	localparam int DefaultRows         = 12;
	localparam int DefaultCols         = 8;
	localparam int DefaultFramesPerCol = 20;

	typedef logic [4:0] rowSel_t;  // row number, 1..NumberOfRows
	typedef logic [7:0] cfgByte_t; // one byte from the UART or parallel port

	// row code driven when no data word is on the bus
	localparam rowSel_t RowSelIdle = '1;

endpackage

// File: ConfigWordAssembler.sv
`timescale 1ns/1ps

module ConfigWordAssembler import fabricGeomPkg::*, cfgProtocolPkg::*; #(
	parameter int CreditDepth = 4
) (
	input  logic     CLK,
	input  logic     rst,
	input  logic     byteValid,  // one byte per cycle, only with credit
	input  cfgByte_t byteData,
	output logic     byteCredit, // one credit back per popped byte
	output logic     wordStrobe, // one cycle per packed word
	output cfgWord_t wordData
);

	localparam int PtrW = (CreditDepth > 1) ? $clog2(CreditDepth) : 1;
	localparam int CntW = $clog2(CreditDepth + 1);

	cfgByte_t            fifoMem [CreditDepth]; // circular byte buffer
	logic     [PtrW-1:0] wrPtr;
	logic     [PtrW-1:0] rdPtr;
	logic     [CntW-1:0] fillCnt;               // bytes currently held
	logic                popByte;
	logic     [1:0]      byteCnt;               // bytes already in shiftReg
	cfgWord_t            shiftReg;              // msb first packing

	// pop whenever something is buffered, credit goes back right away
	assign popByte    = (fillCnt != '0);
	assign byteCredit = popByte;

	always_ff @(posedge CLK) begin
		if (byteValid) begin
			fifoMem[wrPtr] <= byteData; // no full check, credits prevent overflow
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fillCnt <= '0;
		end else begin
			if (byteValid) begin
				wrPtr <= (wrPtr == PtrW'(CreditDepth - 1)) ? '0 : wrPtr + 1'b1; // wrap
			end
			if (popByte) begin
				rdPtr <= (rdPtr == PtrW'(CreditDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({byteValid, popByte})
				2'b10:   fillCnt <= fillCnt + 1'b1;
				2'b01:   fillCnt <= fillCnt - 1'b1;
				default: fillCnt <= fillCnt; // both or neither
			endcase
		end
	end

	// shift the popped byte in from the bottom, first byte ends up on top
	always_ff @(posedge CLK) begin
		if (popByte) begin
			shiftReg <= {shiftReg[23:0], fifoMem[rdPtr]};
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			byteCnt    <= '0;
			wordStrobe <= 1'b0;
		end else begin
			wordStrobe <= popByte && (byteCnt == 2'd3); // fourth byte completes a word
			if (popByte) begin
				byteCnt <= byteCnt + 1'b1; // wraps to zero after four
			end
		end
	end

	assign wordData = shiftReg; // valid while wordStrobe is high

endmodule

// File: ConfigFSM.sv
`timescale 1ns/1ps

module ConfigFSM import cfgProtocolPkg::*, fabricGeomPkg::*; #(
	parameter int NumberOfRows = DefaultRows
) (
	input  logic         CLK,
	input  logic         rst,
	input  logic         wordStrobe,
	input  cfgWord_t     wordData,
	output rowSel_t      rowSelect,      // remaining rows while wordStrobe, idle code otherwise
	output frameHeader_t frameAddr,      // header of the frame being written
	output logic         longFrameStrobe // two cycles per completed frame
);

	cfgState_t state;
	rowSel_t   rowCount;       // rows still to come in this frame
	logic      lastRow;        // last data word taken on the previous edge
	logic      frameStrobe;    // one cycle pulse, one edge after lastRow
	logic      oldFrameStrobe; // frameStrobe delayed for the stretch

	// anything before the sync word is skipped, so a port header or
	// metadata can sit in front of the bitstream as long as it is word padded
	always_ff @(posedge CLK) begin
		if (rst) begin
			state    <= unsynced;
			rowCount <= '0;
			lastRow  <= 1'b0;
		end else begin
			lastRow <= 1'b0; // single cycle flag
			case (state)
				unsynced: begin
					if (wordStrobe && (wordData == SyncWord)) begin
						state <= synced; // aligned, next word is a header
					end
				end
				synced: begin
					if (wordStrobe) begin
						if (wordData[DesyncBit]) begin
							state <= unsynced; // end of session
						end else begin
							rowCount <= rowSel_t'(NumberOfRows); // top row first
							state    <= loadRows;
						end
					end
				end
				loadRows: begin
					if (wordStrobe) begin
						rowCount <= rowCount - 1'b1;
						if (rowCount == rowSel_t'(1)) begin
							lastRow <= 1'b1;   // frame complete
							state   <= synced; // next header or desync
						end
					end
				end
				default: state <= unsynced; // recover from an illegal code
			endcase
		end
	end

	// header register, words come at most every fourth cycle so a new
	// header never lands before the previous long strobe has ended
	always_ff @(posedge CLK) begin
		if ((state == synced) && wordStrobe && !wordData[DesyncBit]) begin
			frameAddr <= frameHeader_t'(wordData);
		end
	end

	always_comb begin
		if (wordStrobe) begin
			rowSelect = rowCount; // row that takes this word
		end else begin
			rowSelect = RowSelIdle; // no row matches
		end
	end

	// lastRow -> frameStrobe -> two cycle stretch
	always_ff @(posedge CLK) begin
		if (rst) begin
			frameStrobe     <= 1'b0;
			oldFrameStrobe  <= 1'b0;
			longFrameStrobe <= 1'b0;
		end else begin
			frameStrobe     <= lastRow;
			oldFrameStrobe  <= frameStrobe;
			longFrameStrobe <= frameStrobe || oldFrameStrobe;
		end
	end

endmodule

// File: FrameDataRegister.sv
`timescale 1ns/1ps

module FrameDataRegister import cfgProtocolPkg::*, fabricGeomPkg::*; #(
	parameter int NumberOfRows = DefaultRows
) (
	input  logic                        CLK,
	input  logic                        rst,
	input  logic                        wordStrobe,
	input  rowSel_t                     rowSelect,
	input  cfgWord_t                    wordData,
	output logic [NumberOfRows*32-1:0]  frameData // row 1 in the low word
);

	logic [NumberOfRows-1:0] rowLoad; // one load enable per row

	// row r sits at frameData[(r-1)*32 +: 32]
	genvar r;
	generate
		for (r = 0; r < NumberOfRows; r++) begin : genRow
			assign rowLoad[r] = wordStrobe && (rowSelect == rowSel_t'(r + 1));

			always_ff @(posedge CLK) begin
				if (rst) begin
					frameData[r*32 +: 32] <= '0;
				end else if (rowLoad[r]) begin
					frameData[r*32 +: 32] <= wordData; // holds until the row is written again
				end
			end
		end
	endgenerate

endmodule

// File: FrameSelectDecoder.sv
`timescale 1ns/1ps

module FrameSelectDecoder import cfgProtocolPkg::*, fabricGeomPkg::*; #(
	parameter int NumberOfCols = DefaultCols,
	parameter int FramesPerCol = DefaultFramesPerCol
) (
	input  logic                                  longFrameStrobe,
	input  frameHeader_t                          frameAddr,
	output logic [NumberOfCols*FramesPerCol-1:0]  frameSelect // one-hot or zero
);

	localparam int SelW = NumberOfCols * FramesPerCol;

	logic colOk;   // column inside the fabric
	logic frameOk; // frame inside the column
	int   selIdx;  // flat bit position

	assign colOk   = (int'(frameAddr.colIdx) < NumberOfCols);
	assign frameOk = (int'(frameAddr.frameIdx) < FramesPerCol);
	assign selIdx  = int'(frameAddr.colIdx) * FramesPerCol + int'(frameAddr.frameIdx);

	always_comb begin
		frameSelect = '0;
		if (longFrameStrobe && colOk && frameOk) begin
			frameSelect = SelW'(1) << selIdx; // column major, frames consecutive
		end
	end

endmodule

// File: ConfigTop.sv
`timescale 1ns/1ps

module ConfigTop import cfgProtocolPkg::*, fabricGeomPkg::*; #(
	parameter int NumberOfRows = DefaultRows,
	parameter int NumberOfCols = DefaultCols,
	parameter int FramesPerCol = DefaultFramesPerCol,
	parameter int CreditDepth  = 4
) (
	input  logic                                  CLK,
	input  logic                                  rst,
	input  logic                                  byteValid,
	input  cfgByte_t                              byteData,
	output logic                                  byteCredit,
	output logic [NumberOfRows*32-1:0]            frameData,
	output logic [NumberOfCols*FramesPerCol-1:0]  frameSelect,
	output logic                                  longFrameStrobe
);

	logic         wordStrobe; // assembler to FSM and row registers
	cfgWord_t     wordData;
	rowSel_t      rowSelect;
	frameHeader_t frameAddr;  // latched header for the decoder

	// bytes in, words out, credits back to the source
	ConfigWordAssembler #(
		.CreditDepth(CreditDepth)
	) i_ConfigWordAssembler (
		.CLK       (CLK),
		.rst       (rst),
		.byteValid (byteValid),
		.byteData  (byteData),
		.byteCredit(byteCredit),
		.wordStrobe(wordStrobe),
		.wordData  (wordData)
	);

	ConfigFSM #(
		.NumberOfRows(NumberOfRows)
	) i_ConfigFSM (
		.CLK            (CLK),
		.rst            (rst),
		.wordStrobe     (wordStrobe),
		.wordData       (wordData),
		.rowSelect      (rowSelect),
		.frameAddr      (frameAddr),
		.longFrameStrobe(longFrameStrobe)
	);

	FrameDataRegister #(
		.NumberOfRows(NumberOfRows)
	) i_FrameDataRegister (
		.CLK       (CLK),
		.rst       (rst),
		.wordStrobe(wordStrobe),
		.rowSelect (rowSelect),
		.wordData  (wordData),
		.frameData (frameData)
	);

	FrameSelectDecoder #(
		.NumberOfCols(NumberOfCols),
		.FramesPerCol(FramesPerCol)
	) i_FrameSelectDecoder (
		.longFrameStrobe(longFrameStrobe),
		.frameAddr      (frameAddr),
		.frameSelect    (frameSelect)
	);

endmodule

// File: tbConfig_assertions.sv
`timescale 1ns/1ps

module tbConfig_assertions import cfgProtocolPkg::*, fabricGeomPkg::*; #(
	parameter int NumberOfRows = DefaultRows
) (
	input logic      CLK,
	input logic      rst,
	input logic      wordStrobe,
	input rowSel_t   rowSelect,
	input logic      longFrameStrobe,
	input cfgState_t state
);

	// first strobe cycle is always followed by a second one
	strobeSecondCycle: assert property (@(posedge CLK) disable iff (rst)
		(longFrameStrobe && !$past(longFrameStrobe)) |=> longFrameStrobe)
		else begin
			tbConfigTop.assertErrors++;
			$error("long frame strobe ended after a single cycle");
		end

	// and the second one is the last
	strobeEnds: assert property (@(posedge CLK) disable iff (rst)
		(longFrameStrobe && $past(longFrameStrobe)) |=> !longFrameStrobe)
		else begin
			tbConfigTop.assertErrors++;
			$error("long frame strobe held longer than two cycles");
		end

	rowInRange: assert property (@(posedge CLK) disable iff (rst)
		wordStrobe |-> (rowSelect <= rowSel_t'(NumberOfRows))) // never past the top row
		else begin
			tbConfigTop.assertErrors++;
			$error("row select %0d beyond the fabric height", rowSelect);
		end

	stateLegal: assert property (@(posedge CLK) disable iff (rst)
		(state == unsynced) || (state == synced) || (state == loadRows))
		else begin
			tbConfigTop.assertErrors++;
			$error("FSM in an illegal state code %0d", state);
		end

endmodule

// File: tbConfigTop.sv
`timescale 1ns/1ps

module tbConfigTop import cfgProtocolPkg::*, fabricGeomPkg::*; ();

	localparam int Rows        = DefaultRows;
	localparam int Cols        = DefaultCols;
	localparam int Fpc         = DefaultFramesPerCol;
	localparam int CreditDepth = 4;
	localparam int SelW        = Cols * Fpc;

	typedef logic [Rows*32-1:0] frameData_t; // all row registers
	typedef logic [SelW-1:0]    frameSel_t;  // one-hot frame select

	typedef struct packed {
		frameHeader_t hdr;  // header as sent
		frameData_t   data; // first sent word on top
	} expFrame_t;

	logic       CLK;
	logic       rst;
	logic       byteValid;
	cfgByte_t   byteData;
	logic       byteCredit;
	frameData_t frameData;
	frameSel_t  frameSelect;
	logic       longFrameStrobe;

	cfgByte_t  byteQ[$];     // whole stream, msb of each word first
	int        frameEndQ[$]; // frame index on the last byte of a frame, else -1
	expFrame_t frameList[$]; // frames that must strobe, in order

	int   creditsUsed   = 0; // bytes sent
	int   creditsBack   = 0; // byteCredit pulses seen
	int   framesSent    = 0; // frames whose last byte left the source
	int   framesChecked = 0;
	int   cycleCount    = 0;
	int   cycleLimit    = 0; // set once the stream length is known
	int   dataErrors    = 0;
	int   selectErrors  = 0;
	int   otherErrors   = 0;
	int   assertErrors  = 0; // bumped by the bound FSM assertions
	logic strobeSeen;

	ConfigTop #(
		.NumberOfRows(Rows),
		.NumberOfCols(Cols),
		.FramesPerCol(Fpc),
		.CreditDepth (CreditDepth)
	) i_ConfigTop (
		.CLK            (CLK),
		.rst            (rst),
		.byteValid      (byteValid),
		.byteData       (byteData),
		.byteCredit     (byteCredit),
		.frameData      (frameData),
		.frameSelect    (frameSelect),
		.longFrameStrobe(longFrameStrobe)
	);

	bind ConfigFSM tbConfig_assertions #(
		.NumberOfRows(NumberOfRows)
	) i_fsmAssertions (
		.CLK            (CLK),
		.rst            (rst),
		.wordStrobe     (wordStrobe),
		.rowSelect      (rowSelect),
		.longFrameStrobe(longFrameStrobe),
		.state          (state)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 8 ns period
	end

	// expected select from the header, column major with frames consecutive
	function frameSel_t expectSelect(input frameHeader_t h);
		frameSel_t sel;
		sel = '0;
		for (int c = 0; c < Cols; c++) begin
			for (int f = 0; f < Fpc; f++) begin
				if ((int'(h.colIdx) == c) && (int'(h.frameIdx) == f)) begin
					sel[c*Fpc + f] = 1'b1;
				end
			end
		end
		return sel; // stays zero when out of range
	endfunction

	function cfgWord_t randomJunk();
		cfgWord_t w;
		w = $urandom;
		while (w == SyncWord) begin
			w = $urandom; // junk must never sync by accident
		end
		return w;
	endfunction

	function frameHeader_t makeHeader(input bit outOfRange, input bit desync);
		frameHeader_t h;
		h        = '0; // reserved bits zero
		h.desync = desync;
		h.colIdx   = 8'($urandom % Cols);
		h.frameIdx = 5'($urandom % Fpc);
		if (outOfRange) begin
			if (($urandom % 2) == 0) begin
				h.colIdx = 8'(Cols + $urandom % (256 - Cols)); // bad column
			end else begin
				h.frameIdx = 5'(Fpc + $urandom % (32 - Fpc)); // bad frame
			end
		end
		return h;
	endfunction

	task pushWord(input cfgWord_t w, input int frameEnd);
		for (int i = 3; i >= 0; i--) begin
			byteQ.push_back(w[i*8 +: 8]);
			frameEndQ.push_back((i == 0) ? frameEnd : -1);
		end
	endtask

	// junk prefix, then sessions of sync, frames, desync and trailing junk
	task buildStream();
		int        nPrefix;
		int        nFrames;
		int        nJunk;
		cfgWord_t  w;
		expFrame_t fr;
		nPrefix = 3 + $urandom % 4;
		for (int i = 0; i < nPrefix; i++) begin
			pushWord(randomJunk(), -1);
		end
		for (int s = 0; s < 3; s++) begin
			pushWord(SyncWord, -1);
			nFrames = 2 + $urandom % 4;
			for (int f = 0; f < nFrames; f++) begin
				fr.hdr  = makeHeader(($urandom % 4) == 0, 1'b0); // a quarter out of range
				fr.data = '0;
				pushWord(cfgWord_t'(fr.hdr), -1);
				for (int r = 0; r < Rows; r++) begin
					w       = $urandom;
					fr.data = {fr.data[Rows*32-33:0], w}; // earlier words move up
					pushWord(w, (r == Rows - 1) ? frameList.size() : -1);
				end
				frameList.push_back(fr);
			end
			pushWord(cfgWord_t'(makeHeader(1'b0, 1'b1)), -1); // desync, no strobe
			nJunk = 2 + $urandom % 3;
			for (int j = 0; j < nJunk; j++) begin
				pushWord(randomJunk(), -1); // ignored until the next sync
			end
		end
	endtask

	// waits for a free credit and a coin flip, then drives one byte
	task sendByte(input cfgByte_t b, input int frameEnd);
		bit sent;
		int avail;
		sent = 1'b0;
		while (!sent) begin
			@(posedge CLK);
			#1;
			avail = CreditDepth - creditsUsed + creditsBack;
			if ((avail > 0) && (($urandom % 2) == 1)) begin
				byteValid = 1'b1;
				byteData  = b;
				creditsUsed++;
				sent = 1'b1;
				if (frameEnd >= 0) begin
					framesSent++; // strobe may come from now on
				end
			end else begin
				byteValid = 1'b0;
				byteData  = cfgByte_t'($urandom); // noise on an idle bus
			end
		end
	endtask

	task checkFrameData(input string name, input frameData_t expected, input frameData_t actual);
		if (actual !== expected) begin
			dataErrors++;
			$display("[FAIL] %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task checkFrameSelect(input string name, input frameSel_t expected, input frameSel_t actual);
		if (actual !== expected) begin
			selectErrors++;
			$display("[FAIL] %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	// outputs sampled mid-cycle
	always @(negedge CLK) begin
		if (rst) begin
			strobeSeen = 1'b0;
		end else begin
			if (byteCredit) begin
				creditsBack++;
			end
			if ((creditsBack > creditsUsed) || (creditsUsed - creditsBack > CreditDepth)) begin
				otherErrors++;
				$display("credit count left 0..%0d at cycle %0d", CreditDepth, cycleCount);
			end
			if (longFrameStrobe && !strobeSeen) begin
				if (framesChecked >= framesSent) begin
					otherErrors++; // prefix, desync or junk must not strobe
					$display("long frame strobe without a completed frame at cycle %0d",
						cycleCount);
				end else begin
					checkFrameData($sformatf("frame %0d data", framesChecked),
						frameList[framesChecked].data, frameData);
					checkFrameSelect($sformatf("frame %0d select", framesChecked),
						expectSelect(frameList[framesChecked].hdr), frameSelect);
					framesChecked++;
				end
			end
			if (!longFrameStrobe) begin
				checkFrameSelect("idle select", '0, frameSelect); // gated by the strobe
			end
			strobeSeen = longFrameStrobe;
		end
	end

	always @(posedge CLK) begin
		cycleCount++;
		if ((cycleLimit > 0) && (cycleCount > cycleLimit)) begin
			$display("timeout: stream did not drain within %0d cycles", cycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(97));
		rst       = 1'b1;
		byteValid = 1'b0;
		byteData  = '0;
		buildStream();
		cycleLimit = byteQ.size() * 4 * 2 + 200;
		repeat (8) @(posedge CLK);
		#1;
		rst = 1'b0;
		for (int i = 0; i < byteQ.size(); i++) begin
			sendByte(byteQ[i], frameEndQ[i]);
		end
		@(posedge CLK);
		#1;
		byteValid = 1'b0;
		// drained once every credit is back and every frame has strobed
		while ((framesChecked != framesSent) || (creditsUsed != creditsBack)) begin
			@(negedge CLK);
		end
		repeat (16) @(negedge CLK); // room for a stray strobe
		$display("errors: frameData %0d, frameSelect %0d, other %0d, assertions %0d",
			dataErrors, selectErrors, otherErrors, assertErrors);
		if ((dataErrors + selectErrors + otherErrors + assertErrors) == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
cfgProtocolPkg.sv
fabricGeomPkg.sv
ConfigWordAssembler.sv
ConfigFSM.sv
FrameDataRegister.sv
FrameSelectDecoder.sv
ConfigTop.sv
tbConfig_assertions.sv
tbConfigTop.sv

// File: runSim.sh
#!/bin/sh
# build and run the configuration path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tbConfigTop

# keep running after an assertion error so the testbench can print its summary
./obj_dir/VtbConfigTop +verilator+error+limit+1000 | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "runSim: testbench reported success"
else
	echo "runSim: testbench reported failure"
	exit 1
fi
